// File: frame_pkg.sv
package frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry
    // kept small so a whole frame fits in a short simulation
    localparam int FRAME_WIDTH  = 8;
    localparam int FRAME_HEIGHT = 4;

    ////////////////////////////////////////////////////////////////////////////
    // sample and coordinate widths
    localparam int PIXEL_WIDTH = 8;
    localparam int COORD_WIDTH = 16;

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [COORD_WIDTH-1:0] coord_t;

    ////////////////////////////////////////////////////////////////////////////
    // frame header
    // "BIVFRAME", most significant byte goes out first
    localparam logic [63:0] MAGIC_NUM     = 64'h42_49_56_46_52_41_4D_45;
    localparam int          MAGIC_BYTES   = 8;
    localparam int          HDR_IDX_WIDTH = $clog2(MAGIC_BYTES);

    ////////////////////////////////////////////////////////////////////////////
    // output buffering and flow control
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CREDIT_MAX      = 16;
    localparam int CREDIT_WIDTH    = $clog2(CREDIT_MAX + 1);

    // mid level for the contrast byte
    localparam int Z_OFFSET = 128;

    // serializer FSM
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        Z_BYTE,
        C_BYTE
    } ser_state_e;

endpackage

// File: pixel_stream_if.sv
`timescale 1ns/1ps

interface pixel_stream_if;
    import frame_pkg::*;

    // one pixel pair per valid beat, no stall
    logic   valid;
    pixel_t plus;
    pixel_t minus;
    coord_t row;
    coord_t col;

    modport source (
        output valid,
        output plus,
        output minus,
        output row,
        output col
    );

    modport sink (
        input valid,
        input plus,
        input minus,
        input row,
        input col
    );

endinterface

// File: frame_ingest.sv
`timescale 1ns/1ps

module frame_ingest (
    input  logic              core_clk,
    input  logic              sys_reset,
    input  logic              pix_valid_i,
    input  logic              pix_sof_i,
    input  frame_pkg::pixel_t pix_plus_i,
    input  frame_pkg::pixel_t pix_minus_i,
    pixel_stream_if.source    out_bus
);
    import frame_pkg::*;

    coord_t col_cnt;
    coord_t row_cnt;
    coord_t col_cur;
    coord_t row_cur;
    coord_t col_next;
    coord_t row_next;
    logic   sof_hit;

    ////////////////////////////////////////////////////////////////////////////
    // position tracking

    // sof forces the current pixel to the origin
    assign sof_hit = pix_valid_i && pix_sof_i;
    assign col_cur = sof_hit ? '0 : col_cnt;
    assign row_cur = sof_hit ? '0 : row_cnt;

    // advance from the current pixel, so sof leads to column 1
    always_comb begin
        col_next = col_cnt;
        row_next = row_cnt;
        if (pix_valid_i) begin
            if (col_cur == coord_t'(FRAME_WIDTH - 1)) begin
                col_next = '0;
                if (row_cur == coord_t'(FRAME_HEIGHT - 1)) begin
                    row_next = '0;
                end else begin
                    row_next = row_cur + coord_t'(1);
                end
            end else begin
                col_next = col_cur + coord_t'(1);
                row_next = row_cur;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_cnt       <= '0;
            row_cnt       <= '0;
            out_bus.valid <= 1'b0;
        end else begin
            col_cnt       <= col_next;
            row_cnt       <= row_next;
            out_bus.valid <= pix_valid_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // input register stage
    always_ff @(posedge core_clk) begin
        out_bus.plus  <= pix_plus_i;
        out_bus.minus <= pix_minus_i;
        out_bus.row   <= row_cur;
        out_bus.col   <= col_cur;
    end

endmodule

// File: dual_channel_scale.sv
`timescale 1ns/1ps

module dual_channel_scale (
    input  logic           core_clk,
    input  logic           sys_reset,
    pixel_stream_if.sink   in_bus,
    pixel_stream_if.source out_bus
);
    import frame_pkg::*;

    logic                          s1_valid;
    logic signed [PIXEL_WIDTH:0]   s1_diff;
    logic        [PIXEL_WIDTH:0]   s1_sum;
    coord_t                        s1_row;
    coord_t                        s1_col;
    logic signed [PIXEL_WIDTH+1:0] z_wide;
    logic        [PIXEL_WIDTH:0]   c_round;
    pixel_t                        z_byte;
    pixel_t                        c_byte;

    ////////////////////////////////////////////////////////////////////////////
    // stage one: difference and sum
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_bus.valid;
        end
    end

    always_ff @(posedge core_clk) begin
        s1_diff <= $signed({1'b0, in_bus.plus}) - $signed({1'b0, in_bus.minus});
        s1_sum  <= {1'b0, in_bus.plus} + {1'b0, in_bus.minus};
        s1_row  <= in_bus.row;
        s1_col  <= in_bus.col;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage two: contrast and mean bytes

    // contrast around the mid level, range -127..383 before clamping
    always_comb begin
        z_wide = (PIXEL_WIDTH + 2)'(Z_OFFSET) + (PIXEL_WIDTH + 2)'(s1_diff);
        if (z_wide[PIXEL_WIDTH+1]) begin
            z_byte = '0;
        end else if (z_wide[PIXEL_WIDTH]) begin
            z_byte = '1;
        end else begin
            z_byte = z_wide[PIXEL_WIDTH-1:0];
        end
    end

    // rounded mean, sum plus one never exceeds nine bits
    assign c_round = s1_sum + 1'b1;
    assign c_byte  = c_round[PIXEL_WIDTH:1];

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            out_bus.valid <= 1'b0;
        end else begin
            out_bus.valid <= s1_valid;
        end
    end

    // z rides on plus, c on minus
    always_ff @(posedge core_clk) begin
        out_bus.plus  <= z_byte;
        out_bus.minus <= c_byte;
        out_bus.row   <= s1_row;
        out_bus.col   <= s1_col;
    end

endmodule

// File: frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
    input  logic               core_clk,
    input  logic               sys_reset,
    pixel_stream_if.sink       in_bus,
    input  logic               credit_i,
    output frame_pkg::pixel_t  byte_o,
    output logic               byte_valid_o,
    output logic               overflow_o
);
    import frame_pkg::*;

    // entry layout is {frame start, z, c}
    logic [2*PIXEL_WIDTH:0]     fifo_mem [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0]   fifo_count;
    logic                       fifo_full;
    logic                       fifo_empty;
    logic                       frame_start;
    logic                       wr_en;
    logic                       pop;
    logic                       rd_sof;
    pixel_t                     rd_z;
    pixel_t                     rd_c;

    ser_state_e                 state;
    ser_state_e                 state_next;
    logic [HDR_IDX_WIDTH-1:0]   hdr_idx;
    logic                       hdr_last;
    pixel_t                     cur_z;
    pixel_t                     cur_c;
    logic [CREDIT_WIDTH-1:0]    credit_cnt;
    logic                       send;

    ////////////////////////////////////////////////////////////////////////////
    // pixel FIFO
    assign frame_start = (in_bus.row == '0) && (in_bus.col == '0);
    assign fifo_full   = fifo_count == (FIFO_ADDR_WIDTH + 1)'(FIFO_DEPTH);
    assign fifo_empty  = fifo_count == '0;

    // a pixel arriving on a full FIFO is lost
    assign wr_en = in_bus.valid && !fifo_full;

    assign {rd_sof, rd_z, rd_c} = fifo_mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= {frame_start, in_bus.plus, in_bus.minus};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            if (in_bus.valid && fifo_full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // credit counter
    assign send         = (state != IDLE) && (credit_cnt != '0);
    assign byte_valid_o = send;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            credit_cnt <= '0;
        end else if (credit_i && !send) begin
            if (credit_cnt != CREDIT_WIDTH'(CREDIT_MAX)) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end else if (!credit_i && send) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // byte FSM

    // next entry is taken when idle or right after its predecessor's c byte
    assign pop      = !fifo_empty && ((state == IDLE) || ((state == C_BYTE) && send));
    assign hdr_last = hdr_idx == HDR_IDX_WIDTH'(MAGIC_BYTES - 1);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pop) begin
                    state_next = rd_sof ? HEADER : Z_BYTE;
                end
            end
            HEADER: begin
                if (send && hdr_last) begin
                    state_next = Z_BYTE;
                end
            end
            Z_BYTE: begin
                if (send) begin
                    state_next = C_BYTE;
                end
            end
            C_BYTE: begin
                if (send) begin
                    if (pop) begin
                        state_next = rd_sof ? HEADER : Z_BYTE;
                    end else begin
                        state_next = IDLE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state   <= IDLE;
            hdr_idx <= '0;
        end else begin
            state <= state_next;
            if ((state == HEADER) && send) begin
                hdr_idx <= hdr_last ? '0 : hdr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (pop) begin
            cur_z <= rd_z;
            cur_c <= rd_c;
        end
    end

    // header goes out MSB first
    always_comb begin
        case (state)
            HEADER:  byte_o = MAGIC_NUM[PIXEL_WIDTH*(MAGIC_BYTES-1-int'(hdr_idx)) +: PIXEL_WIDTH];
            Z_BYTE:  byte_o = cur_z;
            C_BYTE:  byte_o = cur_c;
            default: byte_o = '0;
        endcase
    end

endmodule

// File: stereo_preview_top.sv
`timescale 1ns/1ps

module stereo_preview_top (
    input  logic              core_clk,
    input  logic              sys_reset,
    input  logic              pix_valid_i,
    input  logic              pix_sof_i,
    input  frame_pkg::pixel_t pix_plus_i,
    input  frame_pkg::pixel_t pix_minus_i,
    input  logic              credit_i,
    output frame_pkg::pixel_t byte_o,
    output logic              byte_valid_o,
    output logic              overflow_o
);

    ////////////////////////////////////////////////////////////////////////////
    // internal pixel buses
    pixel_stream_if ingest_bus ();

    // plus carries z, minus carries c
    pixel_stream_if scaled_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // input side
    frame_ingest frame_ingest_i (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .pix_valid_i(pix_valid_i),
        .pix_sof_i  (pix_sof_i),
        .pix_plus_i (pix_plus_i),
        .pix_minus_i(pix_minus_i),
        .out_bus    (ingest_bus.source)
    );

    ////////////////////////////////////////////////////////////////////////////
    // contrast and mean
    dual_channel_scale dual_channel_scale_i (
        .core_clk (core_clk),
        .sys_reset(sys_reset),
        .in_bus   (ingest_bus.sink),
        .out_bus  (scaled_bus.source)
    );

    ////////////////////////////////////////////////////////////////////////////
    // byte stream out
    frame_serializer frame_serializer_i (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .in_bus      (scaled_bus.sink),
        .credit_i    (credit_i),
        .byte_o      (byte_o),
        .byte_valid_o(byte_valid_o),
        .overflow_o  (overflow_o)
    );

endmodule

// File: stereo_preview_sva.sv
`timescale 1ns/1ps

module stereo_preview_sva (
    input logic core_clk,
    input logic sys_reset,
    input logic credit_i,
    input logic byte_valid_o,
    input logic overflow_o
);
    import frame_pkg::*;

    int credit_avail;

    // credits seen on the port less the bytes already sent
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            credit_avail <= 0;
        end else if (credit_i && !byte_valid_o) begin
            if (credit_avail < CREDIT_MAX) begin
                credit_avail <= credit_avail + 1;
            end
        end else if (!credit_i && byte_valid_o) begin
            credit_avail <= credit_avail - 1;
        end
    end

    // a byte only goes out against a granted credit
    credit_held: assert property (@(posedge core_clk) disable iff (sys_reset)
        byte_valid_o |-> credit_avail > 0)
        else $error("byte_valid_o high with no credit available");

    // overflow is sticky until reset
    overflow_sticky: assert property (@(posedge core_clk) disable iff (sys_reset)
        overflow_o |=> overflow_o)
        else $error("overflow_o cleared outside reset");

    quiet_after_reset: assert property (@(posedge core_clk)
        $fell(sys_reset) |-> !byte_valid_o)
        else $error("byte_valid_o high right after reset");

endmodule

bind frame_serializer stereo_preview_sva stereo_preview_sva_i (
    .core_clk    (core_clk),
    .sys_reset   (sys_reset),
    .credit_i    (credit_i),
    .byte_valid_o(byte_valid_o),
    .overflow_o  (overflow_o)
);

// File: tb_stereo_preview.sv
`timescale 1ns/1ps

module tb_stereo_preview;
    import frame_pkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int TOTAL_PIXELS   = 67;
    localparam int TIMEOUT_CYCLES = TOTAL_PIXELS * 40 + 500;

    logic   core_clk;
    logic   sys_reset;
    logic   pix_valid_i;
    logic   pix_sof_i;
    pixel_t pix_plus_i;
    pixel_t pix_minus_i;
    logic   credit_i;
    pixel_t byte_o;
    logic   byte_valid_o;
    logic   overflow_o;

    integer seed = 99112;
    logic   credit_auto;
    int     row_m;
    int     col_m;
    int     error_count;
    int     check_count;
    int     test_errors;
    int     bytes_seen;
    int     credits_granted;
    pixel_t exp_q[$];

    stereo_preview_top stereo_preview_top_i (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .pix_plus_i  (pix_plus_i),
        .pix_minus_i (pix_minus_i),
        .credit_i    (credit_i),
        .byte_o      (byte_o),
        .byte_valid_o(byte_valid_o),
        .overflow_o  (overflow_o)
    );

    always #2 core_clk = ~core_clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers

    // z is the mid level plus contrast clamped to a byte
    // c is the rounded mean
    function automatic logic [15:0] expected_zc(input pixel_t p, input pixel_t m);
        int z;
        int c;
        z = Z_OFFSET + int'(p) - int'(m);
        if (z < 0) begin
            z = 0;
        end else if (z > 255) begin
            z = 255;
        end
        c = (int'(p) + int'(m) + 1) / 2;
        return {z[7:0], c[7:0]};
    endfunction

    // no grant once CREDIT_MAX credits are outstanding
    function automatic logic next_credit();
        int   rnd;
        logic grant;
        rnd   = $random(seed);
        grant = credit_auto && (rnd[1:0] != 2'b00) &&
                (credits_granted - bytes_seen < CREDIT_MAX);
        if (grant) begin
            credits_granted++;
        end
        return grant;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("Error at %0t: %s = %0h, expected %0h", $realtime, name, got, exp);
        end
    endtask

    task automatic drive_cycle(input logic valid, input logic sof, input pixel_t p,
                               input pixel_t m, input logic credit);
        @(posedge core_clk);
        #1;
        pix_valid_i = valid;
        pix_sof_i   = sof;
        pix_plus_i  = p;
        pix_minus_i = m;
        credit_i    = credit;
    endtask

    task automatic drive_idle();
        drive_cycle(1'b0, 1'b0, '0, '0, next_credit());
    endtask

    task automatic apply_reset();
        sys_reset   = 1'b1;
        pix_valid_i = 1'b0;
        pix_sof_i   = 1'b0;
        credit_i    = 1'b0;
        exp_q.delete();
        row_m = 0;
        col_m = 0;
        credits_granted = bytes_seen;
        repeat (RESET_CYCLES) @(posedge core_clk);
        #1;
        sys_reset = 1'b0;
    endtask

    // a header is expected wherever the tracked position is the origin
    task automatic send_pixel(input logic sof, input pixel_t p, input pixel_t m);
        logic [15:0] zc;
        if (sof) begin
            row_m = 0;
            col_m = 0;
        end
        if (row_m == 0 && col_m == 0) begin
            for (int i = 0; i < MAGIC_BYTES; i++) begin
                exp_q.push_back(MAGIC_NUM[8*(MAGIC_BYTES-1-i) +: 8]);
            end
        end
        zc = expected_zc(p, m);
        exp_q.push_back(zc[15:8]);
        exp_q.push_back(zc[7:0]);
        col_m++;
        if (col_m == FRAME_WIDTH) begin
            col_m = 0;
            row_m = (row_m + 1) % FRAME_HEIGHT;
        end
        drive_cycle(1'b1, sof, p, m, next_credit());
        repeat (3) drive_idle();
    endtask

    task automatic send_random_pixel(input logic sof);
        int rnd;
        rnd = $random(seed);
        send_pixel(sof, rnd[7:0], rnd[15:8]);
    endtask

    task automatic end_test(input string name, input logic exp_ovf);
        while (exp_q.size() != 0) begin
            drive_idle();
        end
        repeat (4) drive_idle();
        check_value("overflow_o", int'(overflow_o), int'(exp_ovf));
        $display("%s finished with %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output comparer sampling on the falling edge
    always @(negedge core_clk) begin
        if (!sys_reset && byte_valid_o) begin
            bytes_seen++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Unexpected byte %0h at %0t, nothing was pending", byte_o, $realtime);
            end else begin
                check_value("byte_o", int'(byte_o), int'(exp_q.pop_front()));
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge core_clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        int base;
        int n_exp;
        $timeformat(-9, 0, " ns", 0);
        core_clk    = 1'b0;
        pix_plus_i  = '0;
        pix_minus_i = '0;
        credit_auto = 1'b1;
        apply_reset();

        send_pixel(1'b1, 8'd10, 8'd20);
        repeat (3) send_random_pixel(1'b0);
        end_test("header insertion", 1'b0);

        // clamp corners first and then the rest of the frame
        send_pixel(1'b0, 8'd255, 8'd0);
        send_pixel(1'b0, 8'd0, 8'd255);
        send_pixel(1'b0, 8'd255, 8'd255);
        send_pixel(1'b0, 8'd0, 8'd0);
        repeat (FRAME_WIDTH * FRAME_HEIGHT - 8) send_random_pixel(1'b0);
        end_test("contrast and mean", 1'b0);

        repeat (5) send_random_pixel(1'b0);
        end_test("frame wrap", 1'b0);

        repeat (3) send_random_pixel(1'b0);
        send_random_pixel(1'b1);
        repeat (3) send_random_pixel(1'b0);
        end_test("mid-frame sof", 1'b0);

        // credits one at a time
        apply_reset();
        credit_auto = 1'b0;
        send_random_pixel(1'b1);
        repeat (2) send_random_pixel(1'b0);
        base  = bytes_seen;
        n_exp = exp_q.size();
        repeat (40) drive_idle();
        check_value("byte count", bytes_seen - base, 0);
        for (int k = 1; k <= n_exp; k++) begin
            drive_cycle(1'b0, 1'b0, '0, '0, 1'b1);
            repeat (3) drive_idle();
            check_value("byte count", bytes_seen - base, k);
        end
        end_test("credit back-pressure", 1'b0);

        // back to back pixels into a FIFO that never drains
        apply_reset();
        for (int k = 0; k < FIFO_DEPTH + 4; k++) begin
            drive_cycle(1'b1, 1'b0, pixel_t'(k), pixel_t'(k), 1'b0);
        end
        repeat (10) drive_idle();
        check_value("overflow_o", int'(overflow_o), 1);
        repeat (20) drive_idle();
        end_test("overflow flag", 1'b1);

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
frame_pkg.sv
pixel_stream_if.sv
frame_ingest.sv
dual_channel_scale.sv
frame_serializer.sv
stereo_preview_top.sv
stereo_preview_sva.sv
tb_stereo_preview.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_stereo_preview
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = test failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
